// File: design/brisc_pkg.sv
`default_nettype none

package brisc_pkg;

  // datapath word and address widths, fixed for the core
  localparam int unsigned XLEN = 32;
  localparam int unsigned ADDRESS_WIDTH = 16;
  localparam int unsigned BYTE_WIDTH = 8;
  localparam int unsigned WORD_WIDTH = XLEN;

  // cache geometry defaults
  localparam int unsigned NUM_CACHE_LINES = 8;
  localparam int unsigned CACHE_LINE_WIDTH = 128;

  // store queue depth
  localparam int unsigned STB_DEPTH_DEFAULT = 4;

  // cycles from a fill request to the fill strobe
  localparam int unsigned FILL_LATENCY_DEFAULT = 3;

  // store access size
  // only whole words and single bytes are supported
  typedef enum logic {
    W = 1'b0,
    B = 1'b1
  } data_size_e;

endpackage

`default_nettype wire

// File: design/dcache_array.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_array #(
  parameter int unsigned NUM_LINES  = brisc_pkg::NUM_CACHE_LINES,
  parameter int unsigned LINE_WIDTH = brisc_pkg::CACHE_LINE_WIDTH
) (
  input  logic                                clk,
  input  logic                                reset,

  // lookup and store write
  input  logic                                cache_write,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] addr,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] write_addr,
  input  logic [brisc_pkg::XLEN-1:0]          write_data,
  input  brisc_pkg::data_size_e               data_size,
  input  logic                                is_mem,

  // line fill from memory
  input  logic                                fill,
  input  logic [LINE_WIDTH-1:0]               fill_data,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr,

  // dirty victim going back to memory
  output logic                                evict,
  output logic [LINE_WIDTH-1:0]               evict_data,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] evict_addr,

  output logic                                miss,
  output logic [LINE_WIDTH-1:0]               read_data
);

  localparam int unsigned AW = brisc_pkg::ADDRESS_WIDTH;
  localparam int unsigned SET_WIDTH = $clog2(NUM_LINES);
  localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WIDTH / brisc_pkg::BYTE_WIDTH);
  localparam int unsigned TAG_WIDTH = AW - SET_WIDTH - OFFSET_WIDTH;
  localparam int unsigned BYTE_OFFSET_WIDTH =
    $clog2(brisc_pkg::WORD_WIDTH / brisc_pkg::BYTE_WIDTH);
  localparam int unsigned WORD_OFFSET_WIDTH = $clog2(LINE_WIDTH / brisc_pkg::WORD_WIDTH);

  // per line state
  logic [NUM_LINES-1:0]  valid_q;
  logic [NUM_LINES-1:0]  dirty_q;
  logic [TAG_WIDTH-1:0]  tag_q [NUM_LINES];
  logic [LINE_WIDTH-1:0] data_q [NUM_LINES];

  // address fields
  logic [SET_WIDTH-1:0]         addr_set;
  logic [SET_WIDTH-1:0]         write_set;
  logic [SET_WIDTH-1:0]         fill_set;
  logic [TAG_WIDTH-1:0]         addr_tag;
  logic [TAG_WIDTH-1:0]         write_tag;
  logic [TAG_WIDTH-1:0]         fill_tag;
  logic [WORD_OFFSET_WIDTH-1:0] word_offset;
  logic [OFFSET_WIDTH-1:0]      byte_offset;

  logic [LINE_WIDTH-1:0] merged_line;

  assign addr_set  = addr[OFFSET_WIDTH +: SET_WIDTH];
  assign write_set = write_addr[OFFSET_WIDTH +: SET_WIDTH];
  assign fill_set  = fill_addr[OFFSET_WIDTH +: SET_WIDTH];

  assign addr_tag  = addr[AW-1:SET_WIDTH+OFFSET_WIDTH];
  assign write_tag = write_addr[AW-1:SET_WIDTH+OFFSET_WIDTH];
  assign fill_tag  = fill_addr[AW-1:SET_WIDTH+OFFSET_WIDTH];

  assign word_offset = write_addr[BYTE_OFFSET_WIDTH +: WORD_OFFSET_WIDTH];
  assign byte_offset = write_addr[OFFSET_WIDTH-1:0];

  // store merge into the current line contents
  // a byte store takes the low byte of write_data
  always_comb begin
    merged_line = data_q[write_set];
    if (data_size == brisc_pkg::W) begin
      merged_line[word_offset*brisc_pkg::WORD_WIDTH +: brisc_pkg::WORD_WIDTH] = write_data;
    end else begin
      merged_line[byte_offset*brisc_pkg::BYTE_WIDTH +: brisc_pkg::BYTE_WIDTH] =
        write_data[brisc_pkg::BYTE_WIDTH-1:0];
    end
  end

  assign miss = is_mem & ~(valid_q[addr_set] & (tag_q[addr_set] == addr_tag));
  assign read_data = data_q[addr_set];

  // victim is whatever sits in the write set right now
  assign evict = valid_q[write_set] & dirty_q[write_set] & (miss | cache_write);
  assign evict_data = data_q[write_set];
  assign evict_addr = {tag_q[write_set], write_set, {OFFSET_WIDTH{1'b0}}};

  // valid and dirty bits, fill wins over a write
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      valid_q[fill_set] <= 1'b1;
      dirty_q[fill_set] <= 1'b0;
    end else if (cache_write) begin
      valid_q[write_set] <= 1'b1;
      dirty_q[write_set] <= 1'b1;
    end
  end

  // tag and data store
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[fill_set]  <= fill_tag;
      data_q[fill_set] <= fill_data;
    end else if (cache_write) begin
      tag_q[write_set]  <= write_tag;
      data_q[write_set] <= merged_line;
    end
  end

endmodule

`default_nettype wire

// File: design/store_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module store_buffer #(
  parameter int unsigned STB_DEPTH = brisc_pkg::STB_DEPTH_DEFAULT
) (
  input  logic                                clk,
  input  logic                                reset,

  // new store from the pipeline
  input  logic                                push,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] push_addr,
  input  logic [brisc_pkg::XLEN-1:0]          push_data,
  input  brisc_pkg::data_size_e               push_size,

  // head consumed by the drain
  input  logic                                pop,

  output logic                                head_valid,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] head_addr,
  output logic [brisc_pkg::XLEN-1:0]          head_data,
  output brisc_pkg::data_size_e               head_size,
  output logic                                full,
  output logic                                empty
);

  localparam int unsigned PTR_WIDTH = (STB_DEPTH > 1) ? $clog2(STB_DEPTH) : 1;
  localparam int unsigned COUNT_WIDTH = $clog2(STB_DEPTH + 1);

  // entry storage
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] addr_q [STB_DEPTH];
  logic [brisc_pkg::XLEN-1:0]          data_q [STB_DEPTH];
  brisc_pkg::data_size_e               size_q [STB_DEPTH];

  logic [PTR_WIDTH-1:0]   wr_ptr_q;
  logic [PTR_WIDTH-1:0]   rd_ptr_q;
  logic [COUNT_WIDTH-1:0] count_q;

  logic do_push;
  logic do_pop;

  // pointer wrap, depth need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(STB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == COUNT_WIDTH'(STB_DEPTH));
  assign empty = (count_q == '0);

  // pushes while full are lost
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign head_valid = ~empty;
  assign head_addr  = addr_q[rd_ptr_q];
  assign head_data  = data_q[rd_ptr_q];
  assign head_size  = size_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_q[wr_ptr_q] <= push_addr;
      data_q[wr_ptr_q] <= push_data;
      size_q[wr_ptr_q] <= push_size;
    end
  end

endmodule

`default_nettype wire

// File: design/miss_handler.sv
`timescale 1ns/10ps
`default_nettype none

module miss_handler #(
  parameter int unsigned LINE_WIDTH = brisc_pkg::CACHE_LINE_WIDTH
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                load_req,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] load_addr,
  input  logic                                grant,

  // head of the store queue
  input  logic                                stb_valid,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] stb_addr,
  input  logic [brisc_pkg::XLEN-1:0]          stb_data,
  input  brisc_pkg::data_size_e               stb_size,

  input  logic                                miss,
  input  logic                                fill,

  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] lookup_addr,
  output logic                                is_mem,
  output logic                                cache_write,
  output logic [brisc_pkg::XLEN-1:0]          write_data,
  output brisc_pkg::data_size_e               data_size,
  output logic                                stb_pop,
  output logic                                fill_req,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] req_addr,
  output logic                                load_miss
);

  localparam int unsigned AW = brisc_pkg::ADDRESS_WIDTH;
  localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WIDTH / brisc_pkg::BYTE_WIDTH);

  localparam logic IDLE      = 1'b0;
  localparam logic WAIT_FILL = 1'b1;

  logic state_q;
  logic drain;

  // stores only get the port when no load wants it
  assign drain = ~load_req & grant & stb_valid;

  // loads take the port ahead of store drains
  assign lookup_addr = load_req ? load_addr : stb_addr;

  // no lookup runs while a fill is out
  assign is_mem = (state_q == IDLE) & (load_req | drain);

  assign req_addr = {lookup_addr[AW-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign fill_req = (state_q == IDLE) & is_mem & miss;

  // store hit writes and retires the head in one cycle
  assign cache_write = (state_q == IDLE) & drain & ~miss;
  assign stb_pop     = cache_write;
  assign write_data  = stb_data;
  assign data_size   = stb_size;

  assign load_miss = load_req & ((state_q == WAIT_FILL) | miss);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else if ((state_q == IDLE) && fill_req) begin
      state_q <= WAIT_FILL;
    end else if ((state_q == WAIT_FILL) && fill) begin
      state_q <= IDLE;
    end
  end

endmodule

`default_nettype wire

// File: design/line_memory.sv
`timescale 1ns/10ps
`default_nettype none

module line_memory #(
  parameter int unsigned LINE_WIDTH    = brisc_pkg::CACHE_LINE_WIDTH,
  parameter int unsigned NUM_MEM_LINES = 4096,
  parameter int unsigned FILL_LATENCY  = brisc_pkg::FILL_LATENCY_DEFAULT
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                fill_req,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] req_addr,

  input  logic                                evict,
  input  logic [LINE_WIDTH-1:0]               evict_data,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] evict_addr,

  output logic                                fill,
  output logic [LINE_WIDTH-1:0]               fill_data,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr
);

  localparam int unsigned LINE_BYTES = LINE_WIDTH / brisc_pkg::BYTE_WIDTH;
  localparam int unsigned OFFSET_WIDTH = $clog2(LINE_BYTES);
  localparam int unsigned INDEX_WIDTH = $clog2(NUM_MEM_LINES);
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / brisc_pkg::WORD_WIDTH;
  localparam int unsigned COUNT_WIDTH = $clog2(FILL_LATENCY + 1);

  logic [LINE_WIDTH-1:0]               mem_q [NUM_MEM_LINES];
  logic [COUNT_WIDTH-1:0]              count_q;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] pend_addr_q;
  logic [INDEX_WIDTH-1:0]              fill_index;
  logic [INDEX_WIDTH-1:0]              evict_index;

  // initial contents, every word holds its own byte address
  function automatic logic [LINE_WIDTH-1:0] pattern_line(input int unsigned index);
    logic [LINE_WIDTH-1:0] line;
    for (int unsigned w = 0; w < WORDS_PER_LINE; w++) begin
      line[w*brisc_pkg::WORD_WIDTH +: brisc_pkg::WORD_WIDTH] =
        brisc_pkg::WORD_WIDTH'(index * LINE_BYTES + w * (brisc_pkg::WORD_WIDTH / 8));
    end
    return line;
  endfunction

  assign fill_index  = pend_addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
  assign evict_index = evict_addr[OFFSET_WIDTH +: INDEX_WIDTH];

  // fill lands on the last count
  assign fill      = (count_q == COUNT_WIDTH'(1));
  assign fill_data = mem_q[fill_index];
  assign fill_addr = pend_addr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (fill_req) begin
      count_q <= COUNT_WIDTH'(FILL_LATENCY);
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_req) begin
      pend_addr_q <= req_addr;
    end
  end

  // write-back of dirty victims
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int unsigned i = 0; i < NUM_MEM_LINES; i++) begin
        mem_q[i] <= pattern_line(i);
      end
    end else if (evict) begin
      mem_q[evict_index] <= evict_data;
    end
  end

endmodule

`default_nettype wire

// File: design/brisc_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module brisc_dcache #(
  parameter int unsigned NUM_LINES    = brisc_pkg::NUM_CACHE_LINES,
  parameter int unsigned LINE_WIDTH   = brisc_pkg::CACHE_LINE_WIDTH,
  parameter int unsigned STB_DEPTH    = brisc_pkg::STB_DEPTH_DEFAULT,
  parameter int unsigned FILL_LATENCY = brisc_pkg::FILL_LATENCY_DEFAULT
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                load_req,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] load_addr,
  output logic                                load_miss,
  output logic [LINE_WIDTH-1:0]               load_line,

  input  logic                                store_push,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] store_addr,
  input  logic [brisc_pkg::XLEN-1:0]          store_data,
  input  brisc_pkg::data_size_e               store_size,
  output logic                                stb_full,
  output logic                                stb_empty,

  input  logic                                grant
);

  localparam int unsigned AW = brisc_pkg::ADDRESS_WIDTH;
  // backing store covers the whole address space
  localparam int unsigned NUM_MEM_LINES = (1 << AW) / (LINE_WIDTH / brisc_pkg::BYTE_WIDTH);

  logic                     stb_valid;
  logic [AW-1:0]            stb_addr;
  logic [brisc_pkg::XLEN-1:0] stb_data;
  brisc_pkg::data_size_e    stb_size;
  logic                     stb_pop;

  logic [AW-1:0]            lookup_addr;
  logic                     is_mem;
  logic                     cache_write;
  logic [brisc_pkg::XLEN-1:0] write_data;
  brisc_pkg::data_size_e    data_size;
  logic                     miss;

  logic                     fill_req;
  logic [AW-1:0]            req_addr;
  logic                     fill;
  logic [LINE_WIDTH-1:0]    fill_data;
  logic [AW-1:0]            fill_addr;
  logic                     evict;
  logic [LINE_WIDTH-1:0]    evict_data;
  logic [AW-1:0]            evict_addr;

  store_buffer #(.STB_DEPTH(STB_DEPTH)) store_buffer_i (
    .clk(clk), .reset(reset),
    .push(store_push), .push_addr(store_addr), .push_data(store_data),
    .push_size(store_size), .pop(stb_pop),
    .head_valid(stb_valid), .head_addr(stb_addr), .head_data(stb_data),
    .head_size(stb_size), .full(stb_full), .empty(stb_empty)
  );

  miss_handler #(.LINE_WIDTH(LINE_WIDTH)) miss_handler_i (
    .clk(clk), .reset(reset),
    .load_req(load_req), .load_addr(load_addr), .grant(grant),
    .stb_valid(stb_valid), .stb_addr(stb_addr), .stb_data(stb_data),
    .stb_size(stb_size), .miss(miss), .fill(fill),
    .lookup_addr(lookup_addr), .is_mem(is_mem), .cache_write(cache_write),
    .write_data(write_data), .data_size(data_size), .stb_pop(stb_pop),
    .fill_req(fill_req), .req_addr(req_addr), .load_miss(load_miss)
  );

  // addr and write_addr both carry the lookup address
  dcache_array #(.NUM_LINES(NUM_LINES), .LINE_WIDTH(LINE_WIDTH)) dcache_array_i (
    .clk(clk), .reset(reset),
    .cache_write(cache_write), .addr(lookup_addr), .write_addr(lookup_addr),
    .write_data(write_data), .data_size(data_size), .is_mem(is_mem),
    .fill(fill), .fill_data(fill_data), .fill_addr(fill_addr),
    .evict(evict), .evict_data(evict_data), .evict_addr(evict_addr),
    .miss(miss), .read_data(load_line)
  );

  line_memory #(
    .LINE_WIDTH(LINE_WIDTH), .NUM_MEM_LINES(NUM_MEM_LINES), .FILL_LATENCY(FILL_LATENCY)
  ) line_memory_i (
    .clk(clk), .reset(reset),
    .fill_req(fill_req), .req_addr(req_addr),
    .evict(evict), .evict_data(evict_data), .evict_addr(evict_addr),
    .fill(fill), .fill_data(fill_data), .fill_addr(fill_addr)
  );

endmodule

`default_nettype wire

// File: test/brisc_dcache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module brisc_dcache_checker (
  input logic clk,
  input logic reset,
  input logic store_push,
  input logic stb_full,
  input logic fill_req,
  input logic fill,
  input logic cache_write,
  input logic load_miss
);

  int assert_fail_count = 0;
  logic fill_outstanding_q;

  // a fill is outstanding from the request edge until the fill strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_outstanding_q <= 1'b0;
    end else if (fill_req) begin
      fill_outstanding_q <= 1'b1;
    end else if (fill) begin
      fill_outstanding_q <= 1'b0;
    end
  end

  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    store_push |-> !stb_full)
    else begin
      $error("store pushed while the store buffer is full");
      assert_fail_count++;
    end

  single_fill: assert property (@(posedge clk) disable iff (reset)
    fill_req |-> !fill_outstanding_q)
    else begin
      $error("fill requested while another fill is outstanding");
      assert_fail_count++;
    end

  no_write_during_fill: assert property (@(posedge clk) disable iff (reset)
    !(cache_write && fill))
    else begin
      $error("cache write and fill in the same cycle");
      assert_fail_count++;
    end

  // load_miss clears only on the cycle after a fill
  miss_ends_on_fill: assert property (@(posedge clk) disable iff (reset)
    $fell(load_miss) |-> $past(fill))
    else begin
      $error("load miss cleared without a fill");
      assert_fail_count++;
    end

endmodule

bind brisc_dcache brisc_dcache_checker checker_i (
  .clk(clk), .reset(reset), .store_push(store_push), .stb_full(stb_full),
  .fill_req(fill_req), .fill(fill), .cache_write(cache_write), .load_miss(load_miss)
);

`default_nettype wire

// File: test/brisc_dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module brisc_dcache_tb;

  localparam int NUM_LINES = 4;
  localparam int LINE_WIDTH = 128;
  localparam int STB_DEPTH = 4;
  localparam int FILL_LATENCY = 3;
  localparam int LINE_BYTES = LINE_WIDTH / 8;
  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT_CYCLES = 100;

  localparam logic [2:0] OP_LOAD = 3'd0;
  localparam logic [2:0] OP_STORE = 3'd1;
  localparam logic [2:0] OP_GRANT = 3'd2;
  localparam logic [2:0] OP_SYNC = 3'd3;
  localparam logic [2:0] OP_FULL = 3'd4;

  localparam logic [1:0] HIT_ANY = 2'd0;
  localparam logic [1:0] MUST_HIT = 2'd1;
  localparam logic [1:0] MUST_MISS = 2'd2;

  typedef struct packed {
    logic [2:0]            op;
    logic [15:0]           addr;
    logic [31:0]           data;
    brisc_pkg::data_size_e size;
    logic                  rand_data;
    logic [1:0]            hit;
  } step_t;

  logic clk;
  logic reset;
  logic load_req;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] load_addr;
  logic load_miss;
  logic [LINE_WIDTH-1:0] load_line;
  logic store_push;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] store_addr;
  logic [brisc_pkg::XLEN-1:0] store_data;
  brisc_pkg::data_size_e store_size;
  logic stb_full;
  logic stb_empty;
  logic grant;

  step_t steps[$];
  string step_names[$];
  logic [7:0] model_mem [65536];
  logic [31:0] lfsr_state = 32'd76593;
  int error_count = 0;

  brisc_dcache #(
    .NUM_LINES(NUM_LINES), .LINE_WIDTH(LINE_WIDTH),
    .STB_DEPTH(STB_DEPTH), .FILL_LATENCY(FILL_LATENCY)
  ) brisc_dcache_i (
    .clk(clk), .reset(reset),
    .load_req(load_req), .load_addr(load_addr), .load_miss(load_miss), .load_line(load_line),
    .store_push(store_push), .store_addr(store_addr), .store_data(store_data),
    .store_size(store_size), .stb_full(stb_full), .stb_empty(stb_empty), .grant(grant)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic next_random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_data(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value = {value[30:0], next_random_bit()};
    end
    return value;
  endfunction

  // memory starts with every word holding its own byte address
  task automatic init_model();
    logic [31:0] word;
    for (int a = 0; a < 65536; a += 4) begin
      word = 32'(a);
      for (int k = 0; k < 4; k++) begin
        model_mem[a + k] = word[k*8 +: 8];
      end
    end
  endtask

  task automatic model_store(input logic [15:0] addr, input logic [31:0] data,
                             input brisc_pkg::data_size_e size);
    logic [15:0] base;
    base = {addr[15:2], 2'b00};
    if (size == brisc_pkg::W) begin
      for (int k = 0; k < 4; k++) begin
        model_mem[base + k] = data[k*8 +: 8];
      end
    end else begin
      model_mem[addr] = data[7:0];
    end
  endtask

  function automatic logic [LINE_WIDTH-1:0] model_line(input logic [15:0] addr);
    logic [LINE_WIDTH-1:0] line;
    logic [15:0] base;
    base = addr & ~16'(LINE_BYTES - 1);
    for (int i = 0; i < LINE_BYTES; i++) begin
      line[i*8 +: 8] = model_mem[base + i];
    end
    return line;
  endfunction

  task automatic add_step(input string name, input logic [2:0] op, input logic [15:0] addr,
                          input logic [31:0] data, input brisc_pkg::data_size_e size,
                          input logic rand_data, input logic [1:0] hit);
    steps.push_back('{op, addr, data, size, rand_data, hit});
    step_names.push_back(name);
  endtask

  task automatic build_table();
    add_step("cold_load", OP_LOAD, 16'h0100, 32'h0, brisc_pkg::W, 1'b0, MUST_MISS);
    add_step("load_hit", OP_LOAD, 16'h0100, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("load_hit_offset", OP_LOAD, 16'h010c, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("word_store", OP_STORE, 16'h0104, 32'hcafe_f00d, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("word_store", OP_SYNC, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("word_store", OP_LOAD, 16'h0100, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("byte_store", OP_STORE, 16'h010b, 32'h0000_00a5, brisc_pkg::B, 1'b0, HIT_ANY);
    add_step("byte_store", OP_SYNC, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("byte_store", OP_LOAD, 16'h0100, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    // same set, other tag, pushes the dirty line out
    add_step("conflict_load", OP_LOAD, 16'h0140, 32'h0, brisc_pkg::W, 1'b0, MUST_MISS);
    add_step("write_back", OP_LOAD, 16'h0100, 32'h0, brisc_pkg::W, 1'b0, MUST_MISS);
    add_step("store_allocate", OP_STORE, 16'h0213, 32'h0, brisc_pkg::B, 1'b1, HIT_ANY);
    add_step("store_allocate", OP_SYNC, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("store_allocate", OP_LOAD, 16'h0210, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("back_pressure", OP_GRANT, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("back_pressure", OP_STORE, 16'h0220, 32'h0, brisc_pkg::W, 1'b1, HIT_ANY);
    add_step("back_pressure", OP_STORE, 16'h0224, 32'h0, brisc_pkg::W, 1'b1, HIT_ANY);
    add_step("back_pressure", OP_STORE, 16'h0224, 32'h0, brisc_pkg::W, 1'b1, HIT_ANY);
    add_step("back_pressure", OP_STORE, 16'h0231, 32'h0, brisc_pkg::B, 1'b1, HIT_ANY);
    add_step("back_pressure", OP_FULL, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("back_pressure", OP_GRANT, 16'h0, 32'h1, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("back_pressure", OP_SYNC, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("back_pressure", OP_LOAD, 16'h0220, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("back_pressure", OP_LOAD, 16'h0230, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    // load arrives while the queue still holds stores
    add_step("load_priority", OP_GRANT, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("load_priority", OP_STORE, 16'h0320, 32'h0, brisc_pkg::W, 1'b1, HIT_ANY);
    add_step("load_priority", OP_STORE, 16'h0324, 32'h0, brisc_pkg::W, 1'b1, HIT_ANY);
    add_step("load_priority", OP_GRANT, 16'h0, 32'h1, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("load_priority", OP_LOAD, 16'h0150, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("load_priority", OP_SYNC, 16'h0, 32'h0, brisc_pkg::W, 1'b0, HIT_ANY);
    add_step("load_priority", OP_LOAD, 16'h0320, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("load_priority", OP_LOAD, 16'h0150, 32'h0, brisc_pkg::W, 1'b0, MUST_HIT);
    add_step("refetch", OP_LOAD, 16'h0220, 32'h0, brisc_pkg::W, 1'b0, MUST_MISS);
    add_step("refetch", OP_LOAD, 16'h0210, 32'h0, brisc_pkg::W, 1'b0, MUST_MISS);
  endtask

  // outputs are sampled a quarter period after the falling edge
  task automatic check_load(input string name, input logic [15:0] addr, input logic [1:0] hit);
    logic [LINE_WIDTH-1:0] expected;
    logic first_miss;
    int cycles;
    expected = model_line(addr);
    cycles = 0;
    @(negedge clk);
    load_req = 1'b1;
    load_addr = addr;
    #(CLK_PERIOD / 4);
    first_miss = load_miss;
    while (load_miss && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      cycles++;
    end
    if (load_miss) begin
      error_count++;
      $display("%s: load of %h still missing after %0d cycles", name, addr, cycles);
    end else if (load_line !== expected) begin
      error_count++;
      $display("error %s: expected %h actual %h", name, expected, load_line);
    end
    if (hit == MUST_HIT && first_miss !== 1'b0) begin
      error_count++;
      $display("error %s: expected load_miss 0 actual %b", name, first_miss);
    end
    // miss cycle, then the fill latency, then the hit cycle
    if (hit == MUST_MISS && (first_miss !== 1'b1 || cycles != FILL_LATENCY + 1)) begin
      error_count++;
      $display("error %s: expected miss cycles %0d actual %0d", name, FILL_LATENCY + 1,
               first_miss ? cycles : 0);
    end
    @(negedge clk);
    load_req = 1'b0;
  endtask

  task automatic push_store(input string name, input logic [15:0] addr,
                            input logic [31:0] data, input brisc_pkg::data_size_e size);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (stb_full && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (stb_full) begin
      error_count++;
      $display("%s: store buffer stayed full, store to %h not pushed", name, addr);
    end else begin
      store_push = 1'b1;
      store_addr = addr;
      store_data = data;
      store_size = size;
      model_store(addr, data, size);
      @(negedge clk);
      store_push = 1'b0;
    end
  endtask

  task automatic wait_drained(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!stb_empty && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!stb_empty) begin
      error_count++;
      $display("%s: store buffer did not drain within %0d cycles", name, TIMEOUT_CYCLES);
    end
  endtask

  task automatic run_step(input step_t s, input string name);
    logic [31:0] data;
    case (s.op)
      OP_LOAD: check_load(name, s.addr, s.hit);
      OP_STORE: begin
        data = s.data;
        if (s.rand_data) begin
          data = random_data(s.size == brisc_pkg::W ? 32 : 8);
        end
        push_store(name, s.addr, data, s.size);
      end
      OP_GRANT: begin
        @(negedge clk);
        grant = s.data[0];
      end
      OP_SYNC: wait_drained(name);
      default: begin
        @(negedge clk);
        if (stb_full !== 1'b1) begin
          error_count++;
          $display("error %s: expected stb_full 1 actual %b", name, stb_full);
        end
      end
    endcase
  endtask

  initial begin
    reset = 1'b1;
    load_req = 1'b0;
    load_addr = '0;
    store_push = 1'b0;
    store_addr = '0;
    store_data = '0;
    store_size = brisc_pkg::W;
    grant = 1'b1;
    init_model();
    build_table();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    foreach (steps[i]) begin
      run_step(steps[i], step_names[i]);
    end
    repeat (4) @(negedge clk);
    $display("checks done: %0d testbench errors, %0d assertion failures", error_count,
             brisc_dcache_i.checker_i.assert_fail_count);
    if (error_count == 0 && brisc_dcache_i.checker_i.assert_fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: brisc_dcache.f
design/brisc_pkg.sv
design/dcache_array.sv
design/store_buffer.sv
design/miss_handler.sv
design/line_memory.sv
design/brisc_dcache.sv
test/brisc_dcache_checker.sv
test/brisc_dcache_tb.sv

// File: Makefile
TOP = brisc_dcache_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f brisc_dcache.f -o sim
	-./obj_dir/sim +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); \
	then echo "simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
